// File: Makefile
# Verilator simulation of the convolution engine testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module conv_tb -f filelist.f -o conv_sim

run: compile
	./obj_dir/conv_sim | tee sim.log
	grep -q "^PASS: all tests$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: common/conv_cfg.svh
// Build-time sizes of the convolution engine.
// CONV_MEMBERS must be a multiple of 3, so that a kw=3 group never spans two beats.
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// Pixels per input beat
`define CONV_UNITS      2

// Weights per input beat
`define CONV_MEMBERS    6

// Pixel and weight width
`define CONV_WORD_IN    8

// Accumulator width, with headroom for long channel runs
`define CONV_WORD_ACC   24

// User tag carried alongside each beat
`define CONV_TAG_BITS   4

// Input FIFO entries
`define CONV_FIFO_DEPTH 2

`endif

// File: common/conv_ctrl_pkg.sv
// Control types. The kernel width is 2*kw2+1, so it is either 1 or 3.
`default_nettype none

`include "conv_cfg.svh"

package conv_ctrl_pkg;

  // Free-running tag, passed through to the output
  typedef logic [`CONV_TAG_BITS-1:0] tag_t;

  // Counts the kw-1 shift cycles
  typedef logic [1:0] shift_cnt_t;

  typedef struct packed {
    logic kw2;      // Kernel width select
    logic cin_last; // Closes a channel group
    tag_t tag;
  } conv_user_t;

  // Engine phase
  typedef enum logic {
    PH_MAC,
    PH_SHIFT
  } conv_phase_t;

endpackage

`default_nettype wire

// File: common/conv_data_pkg.sv
// Data-path types. All words are two's complement signed values.
`default_nettype none

`include "conv_cfg.svh"

package conv_data_pkg;

  // Pixel or weight
  typedef logic signed [`CONV_WORD_IN-1:0] word_t;

  // Accumulated sum
  typedef logic signed [`CONV_WORD_ACC-1:0] acc_t;

  // One bit per member
  typedef logic [`CONV_MEMBERS-1:0] keep_t;

  // Input beat, weights in the upper bits
  typedef struct packed {
    word_t [`CONV_MEMBERS-1:0] weights;
    word_t [`CONV_UNITS-1:0]   pixels;
  } conv_in_t;

  // Output beat with the full member x unit array
  typedef struct packed {
    acc_t [`CONV_MEMBERS-1:0][`CONV_UNITS-1:0] sums;
    keep_t                                      keep;
  } conv_out_t;

endpackage

`default_nettype wire

// File: filelist.f
+incdir+common
common/conv_data_pkg.sv
common/conv_ctrl_pkg.sv
hw/conv_engine/conv_mac.sv
hw/conv_engine/conv_engine.sv
hw/conv_in_fifo.sv
hw/conv_out_filter.sv
hw/conv_top.sv
verification/conv_tb.sv

// File: hw/conv_engine/conv_engine.sv
// Multiply-accumulate array with member chaining for kernel widths 1 and 3.
// After a cin_last beat with kw=3, q_ready drops while the group sums are built.
// The output has no ready, so e_valid pulses once per group.
`timescale 1ns/1ps
`default_nettype none

`include "conv_cfg.svh"

module conv_engine (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      q_valid,
  output logic                      q_ready,
  input  logic                      q_last,
  input  conv_ctrl_pkg::conv_user_t q_user,
  input  conv_data_pkg::conv_in_t   q_data,
  output logic                      e_valid,
  output logic                      e_last,
  output conv_ctrl_pkg::conv_user_t e_user,
  output conv_data_pkg::conv_out_t  e_sums
);
  import conv_data_pkg::*;
  import conv_ctrl_pkg::*;

  localparam int MEMBERS = `CONV_MEMBERS;
  localparam int UNITS   = `CONV_UNITS;

  acc_t [MEMBERS-1:0][UNITS-1:0] mul_prod;
  acc_t [MEMBERS-1:0][UNITS-1:0] acc_sum;
  acc_t [MEMBERS-1:0][UNITS-1:0] chain_src;
  logic                          mul_valid;
  logic                          mul_last;
  conv_user_t                    mul_user;
  logic                          mul_close;
  logic                          load_pending;
  conv_phase_t                   phase;
  shift_cnt_t                    shift_cnt;
  shift_cnt_t                    last_shift;
  logic                          shift_done;
  logic [MEMBERS-1:0]            chain_en;

  assign mul_close  = mul_valid && mul_user.cin_last;
  assign last_shift = {e_user.kw2, 1'b0}; // kw-1
  assign shift_done = (phase == PH_SHIFT) && (shift_cnt == last_shift);

  // Stall from the cin_last beat until the final shift cycle
  assign q_ready = !(mul_close && mul_user.kw2) &&
                   !((phase == PH_SHIFT) && (shift_cnt != last_shift));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mul_valid <= 1'b0;
    end else begin
      mul_valid <= q_valid && q_ready;
    end
  end

  // Products hold while stalled
  always_ff @(posedge clk) begin
    if (q_valid && q_ready) begin
      mul_last <= q_last;
      mul_user <= q_user;
      for (int m = 0; m < MEMBERS; m++) begin
        for (int u = 0; u < UNITS; u++) begin
          mul_prod[m][u] <= acc_t'(q_data.weights[m]) * acc_t'(q_data.pixels[u]);
        end
      end
    end
  end

  // Next beat after a group close starts fresh
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      load_pending <= 1'b1;
    end else if (mul_valid) begin
      load_pending <= mul_user.cin_last;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase     <= PH_MAC;
      shift_cnt <= '0;
    end else begin
      case (phase)
        PH_MAC: begin
          if (mul_close && mul_user.kw2) begin
            phase     <= PH_SHIFT;
            shift_cnt <= 2'd1;
          end
        end
        PH_SHIFT: begin
          if (shift_done) begin
            phase     <= PH_MAC;
            shift_cnt <= '0;
          end else begin
            shift_cnt <= shift_cnt + 1'b1;
          end
        end
        default: begin
          phase <= PH_MAC;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      e_valid <= 1'b0;
      e_last  <= 1'b0;
    end else begin
      e_valid <= (mul_close && !mul_user.kw2) || shift_done;
      if (mul_close) begin
        e_last <= mul_last;
      end
    end
  end

  // Closing beat's user field, also sets the shift length
  always_ff @(posedge clk) begin
    if (mul_close) begin
      e_user <= mul_user;
    end
  end

  for (genvar m = 0; m < MEMBERS; m++) begin : g_member
    // Only kw=3 ever shifts, so the member position is m mod 3
    localparam shift_cnt_t POS = shift_cnt_t'(m % 3);

    assign chain_en[m] = (phase == PH_SHIFT) && (shift_cnt == POS);

    if (m == 0) begin : g_head
      assign chain_src[m] = '0;
    end else begin : g_link
      assign chain_src[m] = acc_sum[m-1];
    end

    for (genvar u = 0; u < UNITS; u++) begin : g_unit
      conv_mac u_mac (
        .clk      (clk),
        .rst_n    (rst_n),
        .en       (mul_valid),
        .load     (load_pending),
        .chain_en (chain_en[m]),
        .product  (mul_prod[m][u]),
        .chain_in (chain_src[m][u]),
        .sum      (acc_sum[m][u])
      );
    end
  end

  assign e_sums.sums = acc_sum;
  assign e_sums.keep = '0; // Filled in by the output filter

endmodule

`default_nettype wire

// File: hw/conv_engine/conv_mac.sv
// Single accumulator cell. en and chain_en are never high together, and en wins
// if they are.
`timescale 1ns/1ps
`default_nettype none

module conv_mac (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                en,
  input  logic                load,
  input  logic                chain_en,
  input  conv_data_pkg::acc_t product,
  input  conv_data_pkg::acc_t chain_in,
  output conv_data_pkg::acc_t sum
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sum <= '0;
    end else if (en) begin
      if (load) begin
        sum <= product; // First beat of a group
      end else begin
        sum <= sum + product;
      end
    end else if (chain_en) begin
      sum <= sum + chain_in; // Fold in the lower neighbour
    end
  end

endmodule

`default_nettype wire

// File: hw/conv_in_fifo.sv
// Small elastic buffer in front of the engine. No bypass path, so a beat written
// into an empty FIFO shows at the output one cycle later.
`timescale 1ns/1ps
`default_nettype none

`include "conv_cfg.svh"

module conv_in_fifo (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      s_valid,
  output logic                      s_ready,
  input  logic                      s_last,
  input  conv_ctrl_pkg::conv_user_t s_user,
  input  conv_data_pkg::conv_in_t   s_data,
  output logic                      q_valid,
  input  logic                      q_ready,
  output logic                      q_last,
  output conv_ctrl_pkg::conv_user_t q_user,
  output conv_data_pkg::conv_in_t   q_data
);
  import conv_data_pkg::*;
  import conv_ctrl_pkg::*;

  localparam int DEPTH = `CONV_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  typedef struct packed {
    logic       last;
    conv_user_t user;
    conv_in_t   data;
  } entry_t;

  entry_t           mem [DEPTH];
  entry_t           rd_entry;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign s_ready = (count < CNT_W'(DEPTH));
  assign q_valid = (count != '0);
  assign push    = s_valid && s_ready;
  assign pop     = q_valid && q_ready;

  assign rd_entry = mem[rd_ptr];
  assign q_last   = rd_entry.last;
  assign q_user   = rd_entry.user;
  assign q_data   = rd_entry.data;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= '{last: s_last, user: s_user, data: s_data};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

endmodule

`default_nettype wire

// File: hw/conv_out_filter.sv
// Output register stage. The sink must take every beat, since there is no ready.
// Members without keep carry partial sums and are passed through as they are.
`timescale 1ns/1ps
`default_nettype none

`include "conv_cfg.svh"

module conv_out_filter (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      e_valid,
  input  logic                      e_last,
  input  conv_ctrl_pkg::conv_user_t e_user,
  input  conv_data_pkg::conv_out_t  e_sums,
  output logic                      m_valid,
  output logic                      m_last,
  output conv_ctrl_pkg::conv_user_t m_user,
  output conv_data_pkg::conv_out_t  m_data
);
  import conv_data_pkg::*;

  localparam int MEMBERS = `CONV_MEMBERS;

  keep_t keep_mask;

  // Tail member of each group holds the finished sum
  for (genvar m = 0; m < MEMBERS; m++) begin : g_keep
    localparam bit IS_TAIL3 = (m % 3) == 2;

    assign keep_mask[m] = e_user.kw2 ? IS_TAIL3 : 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      m_valid <= 1'b0;
      m_last  <= 1'b0;
    end else begin
      m_valid <= e_valid;
      m_last  <= e_valid && e_last;
    end
  end

  always_ff @(posedge clk) begin
    if (e_valid) begin
      m_data.sums <= e_sums.sums;
      m_data.keep <= keep_mask;
      m_user      <= e_user;
    end
  end

endmodule

`default_nettype wire

// File: hw/conv_top.sv
// Convolution subsystem: input FIFO, MAC engine and output filter.
// The output has no ready, so the sink must accept every beat.
`timescale 1ns/1ps
`default_nettype none

module conv_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      s_valid,
  output logic                      s_ready,
  input  logic                      s_last,
  input  conv_ctrl_pkg::conv_user_t s_user,
  input  conv_data_pkg::conv_in_t   s_data,
  output logic                      m_valid,
  output logic                      m_last,
  output conv_ctrl_pkg::conv_user_t m_user,
  output conv_data_pkg::conv_out_t  m_data
);
  import conv_data_pkg::*;
  import conv_ctrl_pkg::*;

  logic       q_valid;
  logic       q_ready;
  logic       q_last;
  conv_user_t q_user;
  conv_in_t   q_data;
  logic       e_valid;
  logic       e_last;
  conv_user_t e_user;
  conv_out_t  e_sums;

  conv_in_fifo u_fifo (
    .clk, .rst_n,
    .s_valid, .s_ready, .s_last, .s_user, .s_data,
    .q_valid, .q_ready, .q_last, .q_user, .q_data
  );

  conv_engine u_engine (
    .clk, .rst_n,
    .q_valid, .q_ready, .q_last, .q_user, .q_data,
    .e_valid, .e_last, .e_user, .e_sums
  );

  conv_out_filter u_filter (
    .clk, .rst_n,
    .e_valid, .e_last, .e_user, .e_sums,
    .m_valid, .m_last, .m_user, .m_data
  );

endmodule

`default_nettype wire

// File: verification/conv_tb.sv
// Self-checking testbench for conv_top with random beats and a software model.
// Only the tail member of each kernel group is compared, since other members hold partials.
`timescale 1ns/1ps
`default_nettype none

`include "conv_cfg.svh"

module conv_tb;
  import conv_data_pkg::*;
  import conv_ctrl_pkg::*;

  localparam int MEMBERS = `CONV_MEMBERS;
  localparam int UNITS   = `CONV_UNITS;

  logic       clk;
  logic       rst_n;
  logic       s_valid;
  logic       s_ready;
  logic       s_last;
  conv_user_t s_user;
  conv_in_t   s_data;
  logic       m_valid;
  logic       m_last;
  conv_user_t m_user;
  conv_out_t  m_data;

  int         seed;
  int         n_checks;
  int         n_errors;
  int         n_results;
  int         n_sent;
  int         n_groups;
  int         n_cycles;
  bit         stall_seen;
  conv_in_t   grp_q[$];     // Beats of the open group
  conv_out_t  exp_out_q[$];
  conv_user_t exp_user_q[$];
  logic       exp_last_q[$];

  conv_top dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_last  (s_last),
    .s_user  (s_user),
    .s_data  (s_data),
    .m_valid (m_valid),
    .m_last  (m_last),
    .m_user  (m_user),
    .m_data  (m_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Group total over kw members ending at each tail member
  function automatic conv_out_t ref_conv(input conv_in_t beats[$], input logic kw2);
    conv_out_t res;
    int        kw;
    int        total;
    kw  = kw2 ? 3 : 1;
    res = '0;
    for (int m = 0; m < MEMBERS; m++) begin
      if (m % kw == kw - 1) begin
        res.keep[m] = 1'b1;
        for (int u = 0; u < UNITS; u++) begin
          total = 0;
          for (int j = m - kw + 1; j <= m; j++) begin
            foreach (beats[b]) begin
              total += int'(beats[b].weights[j]) * int'(beats[b].pixels[u]);
            end
          end
          res.sums[m][u] = acc_t'(total);
        end
      end
    end
    return res;
  endfunction

  function automatic word_t rand_word();
    return word_t'($random(seed));
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'({$random(seed)} % (hi - lo + 1));
  endfunction

  task automatic check_out(input conv_out_t got, input conv_out_t want);
    n_checks++;
    if (got.keep !== want.keep) begin
      n_errors++;
      $display("FAIL @%0t: keep %b, expected %b", $time, got.keep, want.keep);
    end
    for (int m = 0; m < MEMBERS; m++) begin
      for (int u = 0; u < UNITS; u++) begin
        if (want.keep[m] && got.sums[m][u] !== want.sums[m][u]) begin
          n_errors++;
          $display("FAIL @%0t: sum[%0d][%0d] is %0d, expected %0d",
                   $time, m, u, got.sums[m][u], want.sums[m][u]);
        end
      end
    end
  endtask

  task automatic check_user(input conv_user_t got, input conv_user_t want);
    n_checks++;
    if (got !== want) begin
      n_errors++;
      $display("FAIL @%0t: user kw2=%b last=%b tag=%0d, expected kw2=%b last=%b tag=%0d",
               $time, got.kw2, got.cin_last, got.tag, want.kw2, want.cin_last, want.tag);
    end
  endtask

  task automatic check_bit(input logic got, input logic want, input string what);
    n_checks++;
    if (got !== want) begin
      n_errors++;
      $display("FAIL @%0t: %s is %b, expected %b", $time, what, got, want);
    end
  endtask

  // Holds the beat until the FIFO takes it
  task automatic send_beat(input conv_in_t data, input conv_user_t user, input logic last);
    bit taken;
    taken   = 1'b0;
    n_sent++;
    s_valid = 1'b1;
    s_data  = data;
    s_user  = user;
    s_last  = last;
    while (!taken) begin
      @(negedge clk);
      taken = s_ready;
      @(posedge clk);
      #1;
    end
    s_valid = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic send_group(input int n_beats, input logic kw2, input int gap_max);
    conv_in_t   data;
    conv_user_t user;
    int         r;
    for (int i = 0; i < n_beats; i++) begin
      for (int m = 0; m < MEMBERS; m++) begin
        data.weights[m] = rand_word();
      end
      for (int u = 0; u < UNITS; u++) begin
        data.pixels[u] = rand_word();
      end
      user.kw2      = kw2;
      user.cin_last = (i == n_beats - 1);
      user.tag      = tag_t'(n_groups);
      r = $random(seed);
      send_beat(data, user, r[0]);
      if (gap_max > 0) begin
        idle(rand_range(0, gap_max));
      end
    end
    n_groups++;
  endtask

  task automatic finish_run(input bit timed_out);
    $display("checks %0d, errors %0d, results %0d", n_checks, n_errors, n_results);
    if (n_errors == 0 && !timed_out) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  // Input side model, sampled mid-cycle ahead of the transfer edge
  always @(negedge clk) begin
    if (rst_n && s_valid && s_ready) begin
      grp_q.push_back(s_data);
      if (s_user.cin_last) begin
        exp_out_q.push_back(ref_conv(grp_q, s_user.kw2));
        exp_user_q.push_back(s_user);
        exp_last_q.push_back(s_last);
        grp_q.delete();
      end
    end
    if (rst_n && s_valid && !s_ready) begin
      stall_seen = 1'b1;
    end
  end

  always @(negedge clk) begin
    if (rst_n && m_valid) begin
      if (exp_out_q.size() == 0) begin
        n_errors++;
        $display("FAIL @%0t: output beat with no expected result", $time);
      end else begin
        check_out(m_data, exp_out_q.pop_front());
        check_user(m_user, exp_user_q.pop_front());
        check_bit(m_last, exp_last_q.pop_front(), "m_last");
        n_results++;
      end
    end
  end

  initial begin : watchdog
    n_cycles = 0;
    while (n_cycles < 40 * n_sent + 200) begin
      @(posedge clk);
      n_cycles++;
    end
    $display("Timeout after %0d cycles with %0d results still missing",
             n_cycles, exp_out_q.size());
    finish_run(1'b1);
  end

  initial begin : main
    conv_in_t   edge_beat;
    conv_user_t edge_user;
    rst_n      = 1'b0;
    s_valid    = 1'b0;
    s_last     = 1'b0;
    s_user     = '0;
    s_data     = '0;
    seed       = 32'hc07d;
    n_checks   = 0;
    n_errors   = 0;
    n_results  = 0;
    n_sent     = 0;
    n_groups   = 0;
    stall_seen = 1'b0;
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;
    idle(2);
    check_bit(m_valid, 1'b0, "m_valid after reset");
    check_bit(s_ready, 1'b1, "s_ready after reset");

    // Extreme operands, kw=1
    edge_beat.weights = {-8'sd77, 8'sd0, 8'sd1, -8'sd1, 8'sd127, -8'sd128};
    edge_beat.pixels  = {8'sd127, -8'sd128};
    edge_user         = '{kw2: 1'b0, cin_last: 1'b1, tag: 4'hf};
    send_beat(edge_beat, edge_user, 1'b1);
    for (int g = 0; g < 8; g++) begin
      send_group(1, 1'b0, 2);
    end
    for (int g = 0; g < 6; g++) begin
      send_group(rand_range(2, 4), 1'b0, 2);
    end
    for (int g = 0; g < 6; g++) begin
      send_group(rand_range(1, 3), 1'b1, 2);
    end

    // Back-to-back kw=3 closes fill the FIFO
    for (int g = 0; g < 4; g++) begin
      send_group(1, 1'b1, 0);
    end
    for (int g = 0; g < 40; g++) begin
      send_group(rand_range(1, 3), rand_range(0, 1) == 1, rand_range(0, 1) * 3);
    end

    while (exp_out_q.size() != 0) begin
      @(posedge clk);
    end
    idle(10);
    check_bit(stall_seen, 1'b1, "s_ready drop during shift cycles");
    finish_run(1'b0);
  end

endmodule

`default_nettype wire
